//--- ball_axis_motion.sv
//******************************
// Motion of one axis: fixed-point position and speed, friction on
// every frame tick, cushion bounce with a dead-time, and the event ops.
// Instantiate once per axis with that axis's table size and start.
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "ball_macros.svh"

module ball_axis_motion #(
	parameter int TABLE_SIZE = `TABLE_X_SIZE,  // pixels
	parameter int START_POS  = `BALL_START_X   // pixels
) (
	input  logic                      clk,
	input  logic                      resetN,
	input  logic                      start_of_frame,
	input  ball_event_pkg::event_op_e op,
	input  ball_motion_pkg::speed_t   op_speed,
	input  ball_motion_pkg::speed_t   other_speed,
	output ball_motion_pkg::pos_fp_t  pos,
	output ball_motion_pkg::speed_t   speed
);

	import ball_event_pkg::*;
	import ball_motion_pkg::*;

	localparam int FP_ONE      = 1 << `BALL_FRAC_BITS;
	localparam int START_FP    = START_POS * FP_ONE;
	localparam int NEAR_LIMIT  = `CUSHION_BAND * FP_ONE;
	localparam int FAR_LIMIT   = (TABLE_SIZE - `CUSHION_BAND) * FP_ONE;
	localparam int BALL_FP     = `BALL_SIZE * FP_ONE;
	localparam int DEAD_CNT_W  = $clog2(`BOUNCE_DEAD_TICKS + 1);

	logic [`BALL_SPEED_W-1:0] abs_speed;  // unsigned, holds 1024 too
	logic [`BALL_SPEED_W-1:0] abs_other;
	speed_t                   decel;
	speed_t                   friction_speed;
	logic                     at_cushion;
	logic                     bounce;
	logic                     dead_active;
	logic [DEAD_CNT_W-1:0]    dead_cnt;

	always_comb begin
		abs_speed = (speed < 0) ? -speed : speed;
		abs_other = (other_speed < 0) ? -other_speed : other_speed;

		// the faster axis brakes alone so both reach zero together
		decel = (abs_other > abs_speed) ? speed_t'(0) : speed_t'(`FRICTION_DECEL);

		if (abs_speed <= `STOP_SPEED)
			friction_speed = '0;
		else if (speed < 0)
			friction_speed = speed + decel;
		else
			friction_speed = speed - decel;

		at_cushion = (pos <= NEAR_LIMIT) || ((pos + BALL_FP) >= FAR_LIMIT);
		bounce     = !dead_active && at_cushion;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos         <= pos_fp_t'(START_FP);
			speed       <= '0;
			dead_active <= 1'b0;
			dead_cnt    <= '0;
		end else begin
			// dead-time counts frame ticks, four of them after a bounce
			if (start_of_frame && dead_active) begin
				if (dead_cnt == `BOUNCE_DEAD_TICKS) begin
					dead_cnt    <= '0;
					dead_active <= 1'b0;
				end else begin
					dead_cnt <= dead_cnt + 1'b1;
				end
			end

			case (op)
				EV_POCKET: begin
					pos         <= pos_fp_t'(START_FP);
					speed       <= '0;
					dead_active <= 1'b0;
					dead_cnt    <= '0;
				end
				EV_KICK: speed <= op_speed;
				EV_SLOW: speed <= speed_t'(speed / 2);  // truncates toward zero
				EV_FAST: speed <= speed_t'(speed * 2);
				default: begin
					if (start_of_frame) begin
						pos   <= pos + speed;  // integrate with the old speed
						speed <= friction_speed;
					end else if (bounce) begin
						speed       <= -speed;
						dead_active <= 1'b1;
						dead_cnt    <= '0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- ball_checker.sv
//******************************
// Reference model of the ball and its comparisons. Follows the DUT
// inputs, predicts every pos_valid sample and counts the errors.
// end_test and summary are called from the testbench top.
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "ball_macros.svh"

module ball_checker (
	input logic                    clk,
	input logic                    resetN,
	input logic                    start_of_frame,
	input logic                    pocket_hit,
	input logic                    kick,
	input logic                    fast_gift,
	input logic                    slow_gift,
	input ball_motion_pkg::speed_t kick_x_speed,
	input ball_motion_pkg::speed_t kick_y_speed,
	input ball_motion_pkg::pixel_t top_left_x,
	input ball_motion_pkg::pixel_t top_left_y,
	input ball_motion_pkg::speed_t x_speed,
	input ball_motion_pkg::speed_t y_speed,
	input logic                    moving,
	input logic                    pos_valid
);

	import ball_motion_pkg::*;

	int mx, my, vx, vy, cx, cy;  // model position, speed, dead-time count
	bit dx, dy;                  // dead-time active
	bit exp_pend;
	pixel_t exp_px, exp_py;
	speed_t exp_vx, exp_vy;
	bit exp_mov;
	int err_cnt = 0;
	int test_start = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	function automatic int fric(int s, int o);
		int a;
		int ao;
		int d;
		a = (s < 0) ? -s : s;
		ao = (o < 0) ? -o : o;
		d = (ao > a) ? 0 : `FRICTION_DECEL;
		if (a <= `STOP_SPEED)
			return 0;
		return (s < 0) ? s + d : s - d;
	endfunction

	function automatic bit at_cushion(int p, int size);
		return (p <= `CUSHION_BAND * 64) || (p + `BALL_SIZE * 64 >= (size - `CUSHION_BAND) * 64);
	endfunction

	task automatic bounce_check();
		if (!dx && at_cushion(mx, `TABLE_X_SIZE)) begin
			vx = int'(speed_t'(-vx));
			dx = 1;
			cx = 0;
		end
		if (!dy && at_cushion(my, `TABLE_Y_SIZE)) begin
			vy = int'(speed_t'(-vy));
			dy = 1;
			cy = 0;
		end
	endtask

	task automatic step_dead(inout bit d, inout int c);
		if (d) begin
			if (c == `BOUNCE_DEAD_TICKS) begin
				c = 0;
				d = 0;
			end else begin
				c = c + 1;
			end
		end
	endtask

	task automatic frame_tick();
		int nvx;
		int nvy;
		step_dead(dx, cx);
		step_dead(dy, cy);
		nvx = fric(vx, vy);  // both from the old speeds
		nvy = fric(vy, vx);
		mx = mx + vx;
		my = my + vy;
		vx = nvx;
		vy = nvy;
		exp_px = pixel_t'(mx >>> `BALL_FRAC_BITS);
		exp_py = pixel_t'(my >>> `BALL_FRAC_BITS);
		exp_vx = speed_t'(vx);
		exp_vy = speed_t'(vy);
		exp_mov = (vx != 0) || (vy != 0);
		exp_pend = 1;
		bounce_check();  // reported speeds are the ones before a bounce
	endtask

	always @(posedge clk) begin
		if (!resetN) begin
			mx = `BALL_START_X * 64;
			my = `BALL_START_Y * 64;
			vx = 0;
			vy = 0;
			dx = 0;
			dy = 0;
			cx = 0;
			cy = 0;
			exp_pend = 0;
		end else if (start_of_frame) begin
			frame_tick();
		end else if (pocket_hit || kick || slow_gift || fast_gift) begin
			if (pocket_hit) begin
				mx = `BALL_START_X * 64;
				my = `BALL_START_Y * 64;
				vx = 0;
				vy = 0;
				dx = 0;
				dy = 0;
				cx = 0;
				cy = 0;
			end else if (kick) begin
				vx = int'(kick_x_speed);
				vy = int'(kick_y_speed);
			end else if (slow_gift) begin
				vx = vx / 2;  // toward zero
				vy = vy / 2;
			end else begin
				vx = int'(speed_t'(vx * 2));
				vy = int'(speed_t'(vy * 2));
			end
			bounce_check();
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (resetN && pos_valid) begin
			if (!exp_pend) begin
				err_cnt++;
				$display("pos_valid at %0t with no frame tick before it", $time);
			end else if (top_left_x !== exp_px || top_left_y !== exp_py ||
					x_speed !== exp_vx || y_speed !== exp_vy || moving !== exp_mov) begin
				err_cnt++;
				$write("FAILED %0t: got (%0d,%0d) spd (%0d,%0d) mov %0b",
					$time, top_left_x, top_left_y, x_speed, y_speed, moving);
				$display(", exp (%0d,%0d) spd (%0d,%0d) mov %0b",
					exp_px, exp_py, exp_vx, exp_vy, exp_mov);
			end
			exp_pend = 0;
		end
	end

	task automatic end_test(input int idx, input bit chk_pos, input int ex, input int ey,
			input bit chk_mov, input bit em);
		if (chk_pos && (top_left_x != ex || top_left_y != ey)) begin
			err_cnt++;
			$display("FAILED %0t: test %0d ends at (%0d,%0d), table says (%0d,%0d)",
				$time, idx, top_left_x, top_left_y, ex, ey);
		end
		if (chk_mov && moving != em) begin
			err_cnt++;
			$display("FAILED %0t: test %0d moving %0b, table says %0b", $time, idx, moving, em);
		end
		if (err_cnt == test_start) begin
			tests_ok++;
			$display("test %0d ok at (%0d,%0d)", idx, top_left_x, top_left_y);
		end else begin
			tests_bad++;
			$display("test %0d with %0d errors", idx, err_cnt - test_start);
		end
		test_start = err_cnt;
	endtask

	task automatic summary();
		$display("tests ok %0d, tests bad %0d, check errors %0d", tests_ok, tests_bad, err_cnt);
	endtask

endmodule

`default_nettype wire

//--- ball_event_arbiter.sv
//******************************
// Input side of the ball. Registers the event strobes into one
// prioritized opcode that lasts a single cycle, together with the
// kick speeds. Pocket wins over kick, kick over slow, slow over fast.
//******************************
`timescale 1ns/1ps
`default_nettype none

module ball_event_arbiter (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   pocket_hit,
	input  logic                   kick,
	input  logic                   fast_gift,
	input  logic                   slow_gift,
	input  ball_motion_pkg::speed_t kick_x_speed,
	input  ball_motion_pkg::speed_t kick_y_speed,
	output ball_event_pkg::event_op_e op,
	output ball_motion_pkg::speed_t op_x_speed,
	output ball_motion_pkg::speed_t op_y_speed
);

	import ball_event_pkg::*;
	import ball_motion_pkg::*;

	event_op_e next_op;

	always_comb begin
		if (pocket_hit)
			next_op = EV_POCKET;
		else if (kick)
			next_op = EV_KICK;
		else if (slow_gift)
			next_op = EV_SLOW;
		else if (fast_gift)
			next_op = EV_FAST;
		else
			next_op = EV_NONE;  // lower priority strobes are simply lost
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			op <= EV_NONE;
		end else begin
			op <= next_op;  // one cycle only, back to EV_NONE next
		end
	end

	// kick speeds travel with the opcode
	always_ff @(posedge clk) begin
		if (kick) begin
			op_x_speed <= kick_x_speed;
			op_y_speed <= kick_y_speed;
		end
	end

endmodule

`default_nettype wire

//--- ball_event_pkg.sv
//******************************
// Event opcodes passed from the input arbiter to the axis blocks.
//******************************
`default_nettype none

package ball_event_pkg;

	// one opcode per cycle, EV_NONE when nothing happened
	typedef enum logic [2:0] {
		EV_NONE   = 3'd0,
		EV_POCKET = 3'd1,  // back to start, zero speed
		EV_KICK   = 3'd2,  // load new speed pair
		EV_SLOW   = 3'd3,  // halve both speeds
		EV_FAST   = 3'd4   // double both speeds
	} event_op_e;

endpackage

`default_nettype wire

//--- ball_macros.svh
//******************************
// Shared constants for the ball motion design: widths, fixed-point
// shift, table geometry, friction and cushion dead-time.
// Include wherever a width or a table constant is needed.
//******************************
`ifndef BALL_MACROS_SVH
`define BALL_MACROS_SVH

// widths
`define BALL_SPEED_W      11  // signed speed, 1/64 pixel per frame
`define BALL_POS_W        18  // signed fixed-point position
`define BALL_PIX_W        11  // signed pixel coordinate
`define BALL_FRAC_BITS    6   // 64 sub-steps per pixel

// table geometry in pixels
`define TABLE_X_SIZE      639
`define TABLE_Y_SIZE      479
`define CUSHION_BAND      30
`define BALL_SIZE         32
`define BALL_START_X      150
`define BALL_START_Y      185

// motion
`define FRICTION_DECEL    3   // per frame tick
`define STOP_SPEED        4   // abs speed at or below this stops the axis
`define BOUNCE_DEAD_TICKS 3   // last count of the cushion dead-time

`endif

//--- ball_motion_pkg.sv
//******************************
// Speed, fixed-point position and pixel types of the ball.
// Widths come from the shared macro header.
//******************************
`default_nettype none

`include "ball_macros.svh"

package ball_motion_pkg;

	// 1/64 pixel per frame, sign gives direction
	typedef logic signed [`BALL_SPEED_W-1:0] speed_t;

	// position in 1/64 pixel units
	typedef logic signed [`BALL_POS_W-1:0] pos_fp_t;

	// screen coordinate, can go negative near the edge
	typedef logic signed [`BALL_PIX_W-1:0] pixel_t;

endpackage

`default_nettype wire

//--- ball_motion_top.sv
//******************************
// Top level of the single ball motion model. Events enter through
// the arbiter, two axis blocks move the ball and the output block
// presents the position once per frame.
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "ball_macros.svh"

module ball_motion_top (
	input  logic                    clk,
	input  logic                    resetN,
	input  logic                    start_of_frame,  // one cycle per frame
	input  logic                    pocket_hit,
	input  logic                    kick,
	input  logic                    fast_gift,
	input  logic                    slow_gift,
	input  ball_motion_pkg::speed_t kick_x_speed,   // valid with kick
	input  ball_motion_pkg::speed_t kick_y_speed,
	output ball_motion_pkg::pixel_t top_left_x,
	output ball_motion_pkg::pixel_t top_left_y,
	output ball_motion_pkg::speed_t x_speed,
	output ball_motion_pkg::speed_t y_speed,
	output logic                    moving,
	output logic                    pos_valid
);

	import ball_event_pkg::*;
	import ball_motion_pkg::*;

	event_op_e op;
	speed_t    op_x_speed;
	speed_t    op_y_speed;
	pos_fp_t   x_pos;
	pos_fp_t   y_pos;
	speed_t    x_axis_speed;
	speed_t    y_axis_speed;

	ball_event_arbiter arbiter_i (
		.clk          (clk),
		.resetN       (resetN),
		.pocket_hit   (pocket_hit),
		.kick         (kick),
		.fast_gift    (fast_gift),
		.slow_gift    (slow_gift),
		.kick_x_speed (kick_x_speed),
		.kick_y_speed (kick_y_speed),
		.op           (op),
		.op_x_speed   (op_x_speed),
		.op_y_speed   (op_y_speed)
	);

	ball_axis_motion #(
		.TABLE_SIZE (`TABLE_X_SIZE),
		.START_POS  (`BALL_START_X)
	) x_axis_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.op             (op),
		.op_speed       (op_x_speed),
		.other_speed    (y_axis_speed),  // friction balance
		.pos            (x_pos),
		.speed          (x_axis_speed)
	);

	ball_axis_motion #(
		.TABLE_SIZE (`TABLE_Y_SIZE),
		.START_POS  (`BALL_START_Y)
	) y_axis_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.op             (op),
		.op_speed       (op_y_speed),
		.other_speed    (x_axis_speed),
		.pos            (y_pos),
		.speed          (y_axis_speed)
	);

	ball_position_out out_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.x_pos          (x_pos),
		.y_pos          (y_pos),
		.x_speed_in     (x_axis_speed),
		.y_speed_in     (y_axis_speed),
		.top_left_x     (top_left_x),
		.top_left_y     (top_left_y),
		.x_speed        (x_speed),
		.y_speed        (y_speed),
		.moving         (moving),
		.pos_valid      (pos_valid)
	);

endmodule

`default_nettype wire

//--- ball_position_out.sv
//******************************
// Output side of the ball. One cycle after the frame tick the axis
// state has settled; it is then registered as pixel coordinates,
// speeds and a moving flag, and pos_valid marks the update.
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "ball_macros.svh"

module ball_position_out (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     start_of_frame,
	input  ball_motion_pkg::pos_fp_t x_pos,
	input  ball_motion_pkg::pos_fp_t y_pos,
	input  ball_motion_pkg::speed_t  x_speed_in,
	input  ball_motion_pkg::speed_t  y_speed_in,
	output ball_motion_pkg::pixel_t  top_left_x,
	output ball_motion_pkg::pixel_t  top_left_y,
	output ball_motion_pkg::speed_t  x_speed,
	output ball_motion_pkg::speed_t  y_speed,
	output logic                     moving,
	output logic                     pos_valid
);

	import ball_motion_pkg::*;

	logic frame_d;  // axis update is visible in this cycle

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frame_d   <= 1'b0;
			pos_valid <= 1'b0;
			moving    <= 1'b0;
			x_speed   <= '0;
			y_speed   <= '0;
		end else begin
			frame_d   <= start_of_frame;
			pos_valid <= frame_d;
			if (frame_d) begin
				x_speed <= x_speed_in;
				y_speed <= y_speed_in;
				moving  <= (x_speed_in != 0) || (y_speed_in != 0);
			end
		end
	end

	// drop the fraction bits
	always_ff @(posedge clk) begin
		if (frame_d) begin
			top_left_x <= pixel_t'(x_pos >>> `BALL_FRAC_BITS);
			top_left_y <= pixel_t'(y_pos >>> `BALL_FRAC_BITS);
		end
	end

endmodule

`default_nettype wire

//--- ball_props.sv
//******************************
// Concurrent checks on the ball motion top level, attached with bind
// from the testbench.
//******************************
`timescale 1ns/1ps
`default_nettype none

module ball_props (
	input logic                    clk,
	input logic                    resetN,
	input logic                    start_of_frame,
	input logic                    pocket_hit,
	input logic                    kick,
	input logic                    fast_gift,
	input logic                    slow_gift,
	input ball_motion_pkg::speed_t x_speed,
	input ball_motion_pkg::speed_t y_speed,
	input logic                    moving,
	input logic                    pos_valid
);

	logic any_strobe;
	int   fail_cnt = 0;  // failed assertions so far

	assign any_strobe = start_of_frame | pocket_hit | kick | fast_gift | slow_gift;

	pos_valid_pulse: assert property (@(posedge clk) disable iff (!resetN)
		pos_valid |=> !pos_valid)
		else begin
			fail_cnt++;
			$error("pos_valid held for more than one cycle");
		end

	reset_state: assert property (@(posedge clk)
		$rose(resetN) |-> (x_speed == 0) && (y_speed == 0) && !moving)
		else begin
			fail_cnt++;
			$error("speeds or moving not cleared after reset");
		end

	// sources promise three quiet cycles after any strobe
	strobe_spacing: assert property (@(posedge clk) disable iff (!resetN)
		any_strobe |=> !any_strobe ##1 !any_strobe ##1 !any_strobe)
		else begin
			fail_cnt++;
			$error("input strobes closer than 4 cycles");
		end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
# Build and run the ball motion testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_ball_motion -f vlog.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation ended without a result"; exit 1; }

//--- tb_ball_motion.sv
//******************************
// Testbench of the ball motion top. Applies a table of events and
// frame runs; the checker module predicts and compares the outputs.
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_ball_motion;

	import ball_event_pkg::*;
	import ball_motion_pkg::*;

	typedef struct packed {
		event_op_e kind;
		bit        with_fast;  // fast gift in the same cycle
		bit        rnd;        // random kick speeds
		int        kx;
		int        ky;
		int        frames;
		bit        chk_pos;
		int        ex;
		int        ey;
		bit        chk_mov;
		bit        em;
	} row_t;

	localparam int N_ROWS = 15;

	logic clk, resetN, start_of_frame, pocket_hit, kick, fast_gift, slow_gift;
	speed_t kick_x_speed, kick_y_speed, x_speed, y_speed;
	pixel_t top_left_x, top_left_y;
	logic moving, pos_valid;
	row_t rows [N_ROWS];
	integer seed = 98;
	bit ok;

	ball_motion_top dut_i (.*);
	ball_checker chk_i (.*);

	bind ball_motion_top ball_props props_i (.*);

	initial begin
		clk = 0;
		forever #5 clk = ~clk;
	end

	task automatic wait_pos_valid(output bit got);
		int n;
		got = 0;
		for (n = 0; n < 10 && !got; n++) begin
			@(negedge clk);
			got = pos_valid;
		end
	endtask

	task automatic drive_event(input row_t r);
		@(negedge clk);
		pocket_hit = (r.kind == EV_POCKET);
		kick = (r.kind == EV_KICK);
		slow_gift = (r.kind == EV_SLOW);
		fast_gift = (r.kind == EV_FAST) || r.with_fast;
		kick_x_speed = speed_t'(r.kx);
		kick_y_speed = speed_t'(r.ky);
		@(negedge clk);
		{pocket_hit, kick, slow_gift, fast_gift} = '0;
		repeat (3) @(negedge clk);  // keep clear of the next frame strobe
	endtask

	initial begin
		{start_of_frame, pocket_hit, kick, fast_gift, slow_gift} = '0;
		kick_x_speed = '0;
		kick_y_speed = '0;
		resetN = 0;
		//        kind       fast rnd kx    ky    frm  pos ex   ey   mov em
		rows[0]  = '{EV_NONE,   0, 0, 0,    0,    1,   1, 150, 185, 1, 0};
		rows[1]  = '{EV_KICK,   0, 0, 200,  -100, 110, 0, 0,   0,   1, 0};
		rows[2]  = '{EV_POCKET, 0, 0, 0,    0,    1,   1, 150, 185, 1, 0};
		rows[3]  = '{EV_KICK,   0, 0, 40,   -20,  1,   1, 150, 184, 1, 1};
		rows[4]  = '{EV_FAST,   0, 0, 0,    0,    1,   1, 151, 184, 1, 1};
		rows[5]  = '{EV_SLOW,   0, 0, 0,    0,    1,   1, 152, 183, 1, 1};
		rows[6]  = '{EV_KICK,   1, 0, -12,  7,    1,   1, 152, 183, 1, 1};
		rows[7]  = '{EV_SLOW,   0, 0, 0,    0,    1,   1, 152, 183, 1, 0};
		rows[8]  = '{EV_POCKET, 0, 0, 0,    0,    1,   1, 150, 185, 1, 0};
		rows[9]  = '{EV_KICK,   0, 0, 1000, 0,    30,  1, 569, 185, 1, 1};
		// back into the right cushion while the dead-time still runs
		rows[10] = '{EV_KICK,   0, 0, 700,  0,    3,   1, 602, 185, 1, 1};
		rows[11] = '{EV_POCKET, 0, 0, 0,    0,    1,   1, 150, 185, 1, 0};
		rows[12] = '{EV_KICK,   0, 1, 0,    0,    20,  0, 0,   0,   0, 0};
		rows[13] = '{EV_KICK,   0, 1, 0,    0,    20,  0, 0,   0,   0, 0};
		rows[14] = '{EV_KICK,   0, 1, 0,    0,    20,  0, 0,   0,   0, 0};

		repeat (5) @(negedge clk);
		resetN = 1;

		for (int i = 0; i < N_ROWS; i++) begin
			repeat (4) @(negedge clk);
			if (rows[i].rnd) begin
				rows[i].kx = $random(seed) % 400;
				rows[i].ky = $random(seed) % 400;
			end
			if (rows[i].kind != EV_NONE)
				drive_event(rows[i]);
			for (int f = 0; f < rows[i].frames; f++) begin
				@(negedge clk);
				start_of_frame = 1;
				@(negedge clk);
				start_of_frame = 0;
				wait_pos_valid(ok);
				if (!ok) begin
					$display("timeout: no pos_valid after frame %0d of test %0d", f, i);
					$display("TB FAILED");
					$finish;
				end
				repeat (5) @(negedge clk);  // frame strobes 8 cycles apart
			end
			chk_i.end_test(i, rows[i].chk_pos, rows[i].ex, rows[i].ey,
				rows[i].chk_mov, rows[i].em);
		end

		chk_i.summary();
		if (chk_i.err_cnt == 0 && dut_i.props_i.fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
ball_event_pkg.sv
ball_motion_pkg.sv
ball_event_arbiter.sv
ball_axis_motion.sv
ball_position_out.sv
ball_motion_top.sv
ball_props.sv
ball_checker.sv
tb_ball_motion.sv
